// File: rtl/pipe_ctrl_pkg.sv
`default_nettype none

package pipe_ctrl_pkg;

	typedef logic [4:0] reg_idx_t;

	localparam reg_idx_t REG_ZERO = 5'd0;
	localparam reg_idx_t REG_RA   = 5'd1;   // x1, link register

	// ----------------------------------------
	// rv32i base opcodes
	localparam logic [6:0] OPC_JAL    = 7'b1101111;
	localparam logic [6:0] OPC_JALR   = 7'b1100111;
	localparam logic [6:0] OPC_BRANCH = 7'b1100011;
	localparam logic [6:0] OPC_LOAD   = 7'b0000011;
	localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
	localparam logic [6:0] OPC_OP     = 7'b0110011;
	localparam logic [6:0] OPC_LUI    = 7'b0110111;
	localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
	localparam logic [6:0] OPC_STORE  = 7'b0100011;

	// ----------------------------------------
	// instruction word, two views of the same 32 bits
	typedef struct packed {
		logic [11:0] imm12;
		reg_idx_t    rs1;
		logic [2:0]  func3;
		reg_idx_t    rd;
		logic [6:0]  opcode;
	} inst_i_t;

	typedef struct packed {
		logic [6:0]  imm_hi;
		reg_idx_t    rs2;
		reg_idx_t    rs1;
		logic [2:0]  func3;
		logic [4:0]  imm_lo;
		logic [6:0]  opcode;
	} inst_s_t;

	typedef union packed {
		inst_i_t i_view;   // rd, rs1 and the 12-bit immediate
		inst_s_t s_view;   // rs2 position
	} inst_word_u;

	// ----------------------------------------
	// decoded instruction at the decode boundary
	typedef struct packed {
		reg_idx_t    rs1;
		reg_idx_t    rs2;
		reg_idx_t    rd;
		logic [2:0]  func3;
		logic [11:0] imm12;
		logic        uses_rs1;
		logic        uses_rs2;
		logic        reg_write;   // never set for rd == x0
		logic        mem_read;
		logic        is_jal;
		logic        is_jalr;
		logic        is_branch;
		logic        is_itype_alu;
		logic        imm_is_zero;
	} dec_info_t;

	// per-stage destination info, all zero is a bubble
	typedef struct packed {
		reg_idx_t rd;
		logic     reg_write;
		logic     mem_read;
	} stage_info_t;

	// bit 0 from wb, bit 1 non-load result from mem
	typedef logic [1:0] fwd_sel_t;

	typedef struct packed {
		logic     push;
		logic     pop;
		logic     rollback_pop_id;
		logic     rollback_push_id;
		logic     rollback_push_ex;
		logic     track_wr;   // ra alias update
		reg_idx_t track_rd;
	} ras_ctrl_t;

endpackage

`default_nettype wire

// File: rtl/inst_decode.sv
`timescale 1ns/1ps
`default_nettype none

module inst_decode (
	input  pipe_ctrl_pkg::inst_word_u inst,
	output pipe_ctrl_pkg::dec_info_t  dec
);
	import pipe_ctrl_pkg::*;

	logic [6:0] opcode;
	logic       is_lui;
	logic       is_auipc;
	logic       is_jal;
	logic       is_jalr;
	logic       is_branch;
	logic       is_load;
	logic       is_store;
	logic       is_op_imm;
	logic       is_op;
	logic       writes_rd;   // class has an rd field

	// ----------------------------------------
	// opcode classes
	assign opcode    = inst.i_view.opcode;
	assign is_lui    = (opcode == OPC_LUI);
	assign is_auipc  = (opcode == OPC_AUIPC);
	assign is_jal    = (opcode == OPC_JAL);
	assign is_jalr   = (opcode == OPC_JALR);
	assign is_branch = (opcode == OPC_BRANCH);
	assign is_load   = (opcode == OPC_LOAD);
	assign is_store  = (opcode == OPC_STORE);
	assign is_op_imm = (opcode == OPC_OP_IMM);
	assign is_op     = (opcode == OPC_OP);

	assign writes_rd = is_lui | is_auipc | is_jal | is_jalr | is_load | is_op_imm | is_op;

	// ----------------------------------------
	// fields and flags
	always_comb begin
		dec = '0;

		dec.rs1   = inst.i_view.rs1;
		dec.rs2   = inst.s_view.rs2;   // only the s layout names this slot
		dec.rd    = inst.i_view.rd;
		dec.func3 = inst.i_view.func3;
		dec.imm12 = inst.i_view.imm12;

		// u-type and jal carry no source register
		dec.uses_rs1 = is_jalr | is_branch | is_load | is_store | is_op_imm | is_op;
		dec.uses_rs2 = is_branch | is_store | is_op;

		dec.reg_write = writes_rd && (inst.i_view.rd != REG_ZERO);
		dec.mem_read  = is_load;

		dec.is_jal       = is_jal;
		dec.is_jalr      = is_jalr;
		dec.is_branch    = is_branch;
		dec.is_itype_alu = is_op_imm;

		dec.imm_is_zero = ~|inst.i_view.imm12;   // single 12-input nor
	end

endmodule

`default_nettype wire

// File: rtl/stage_track.sv
`timescale 1ns/1ps
`default_nettype none

module stage_track (
	input  logic                       clk,
	input  logic                       rst_n,
	input  pipe_ctrl_pkg::dec_info_t   dec,
	input  logic                       pl_stall_if,
	input  logic                       pl_stall_ex,
	input  logic                       pl_flush,
	output pipe_ctrl_pkg::stage_info_t st_id,
	output pipe_ctrl_pkg::stage_info_t st_ex,
	output pipe_ctrl_pkg::stage_info_t st_mem,
	output pipe_ctrl_pkg::stage_info_t st_wb
);
	import pipe_ctrl_pkg::*;

	localparam stage_info_t BUBBLE = '0;

	stage_info_t dec_stage;

	assign dec_stage.rd        = dec.rd;
	assign dec_stage.reg_write = dec.reg_write;
	assign dec_stage.mem_read  = dec.mem_read;

	// ----------------------------------------
	// id and ex, held by the ex stall
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			st_id <= BUBBLE;
			st_ex <= BUBBLE;
		end else if (pl_flush) begin
			st_id <= BUBBLE;
			st_ex <= BUBBLE;
		end else if (!pl_stall_ex) begin
			if (pl_stall_if)
				st_id <= BUBBLE;   // instruction comes back next cycle
			else
				st_id <= dec_stage;
			st_ex <= st_id;
		end
	end

	// ----------------------------------------
	// mem and wb keep draining
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			st_mem <= BUBBLE;
			st_wb  <= BUBBLE;
		end else begin
			if (pl_stall_ex)
				st_mem <= BUBBLE;   // ex result not ready
			else
				st_mem <= st_ex;
			st_wb <= st_mem;
		end
	end

	// held stages must not move while ex is stalled
	a_ex_stall_hold: assert property (
		@(posedge clk) disable iff (!rst_n)
		(pl_stall_ex && !pl_flush) |=> ($stable(st_id) && $stable(st_ex))
	) else $error("id/ex stage moved under ex stall");

endmodule

`default_nettype wire

// File: rtl/pipe_hazard_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module pipe_hazard_ctrl (
	input  logic                       clk,
	input  logic                       rst_n,
	input  pipe_ctrl_pkg::dec_info_t   dec,
	input  pipe_ctrl_pkg::stage_info_t st_id,
	input  pipe_ctrl_pkg::stage_info_t st_ex,
	input  pipe_ctrl_pkg::stage_info_t st_mem,
	input  pipe_ctrl_pkg::stage_info_t st_wb,
	input  logic                       pl_flush,
	input  logic                       pl_stall_ex,
	input  logic                       jalr_pred_confirm,
	input  pipe_ctrl_pkg::reg_idx_t    ras_alias,
	output pipe_ctrl_pkg::fwd_sel_t    rs1_fwd,
	output pipe_ctrl_pkg::fwd_sel_t    rs2_fwd,
	output logic                       b_pred_en,
	output logic                       jalr_pred_en,
	output logic                       pl_stall_if,
	output pipe_ctrl_pkg::ras_ctrl_t   ras_ctrl
);
	import pipe_ctrl_pkg::*;

	// source matches a live destination in this stage
	function automatic logic src_hit(input reg_idx_t src, input logic used,
			input stage_info_t st);
		return used && st.reg_write && (st.rd == src);
	endfunction

	logic rs1_hit_id, rs1_hit_ex, rs1_hit_mem, rs1_hit_wb;
	logic rs2_hit_id, rs2_hit_ex, rs2_hit_mem, rs2_hit_wb;
	logic rs1_ex_noload;
	logic rs1_mem_load, rs1_mem_noload;
	logic rs2_mem_load, rs2_mem_noload;

	// ----------------------------------------
	// source vs destination compare
	assign rs1_hit_id  = src_hit(dec.rs1, dec.uses_rs1, st_id);
	assign rs1_hit_ex  = src_hit(dec.rs1, dec.uses_rs1, st_ex);
	assign rs1_hit_mem = src_hit(dec.rs1, dec.uses_rs1, st_mem);
	assign rs1_hit_wb  = src_hit(dec.rs1, dec.uses_rs1, st_wb);

	assign rs2_hit_id  = src_hit(dec.rs2, dec.uses_rs2, st_id);
	assign rs2_hit_ex  = src_hit(dec.rs2, dec.uses_rs2, st_ex);
	assign rs2_hit_mem = src_hit(dec.rs2, dec.uses_rs2, st_mem);
	assign rs2_hit_wb  = src_hit(dec.rs2, dec.uses_rs2, st_wb);

	assign rs1_ex_noload  = rs1_hit_ex && !st_ex.mem_read;
	assign rs1_mem_load   = rs1_hit_mem && st_mem.mem_read;   // data not back yet
	assign rs1_mem_noload = rs1_hit_mem && !st_mem.mem_read;
	assign rs2_mem_load   = rs2_hit_mem && st_mem.mem_read;
	assign rs2_mem_noload = rs2_hit_mem && !st_mem.mem_read;

	assign rs1_fwd = {rs1_mem_noload, rs1_hit_wb};
	assign rs2_fwd = {rs2_mem_noload, rs2_hit_wb};

	assign b_pred_en = dec.is_branch && (rs1_hit_id || rs2_hit_id ||
		rs1_hit_ex || rs2_hit_ex || rs1_mem_load || rs2_mem_load);

	// ----------------------------------------
	// jalr target prediction
	logic compliant_return;
	logic alias_hit;
	logic ras_hit;

	assign compliant_return = (dec.rd == REG_ZERO) && (dec.rs1 == REG_RA) &&
		dec.imm_is_zero;                                          // jalr x0, ra, 0
	assign alias_hit = (dec.rs1 == ras_alias) && (ras_alias != REG_RA);   // via moved ra
	assign ras_hit   = compliant_return || alias_hit;

	assign jalr_pred_en = dec.is_jalr && ras_hit &&
		(rs1_hit_id || rs1_hit_ex || rs1_mem_load);
	assign pl_stall_if = dec.is_jalr && !ras_hit && !rs1_hit_id &&
		(rs1_ex_noload || rs1_mem_load);

	// ----------------------------------------
	// stack control and op history
	logic allow;
	logic push_id;   // call in id pushed
	logic pop_id;
	logic pop_ex;

	assign allow = !pl_flush && !pl_stall_ex && !pl_stall_if;

	always_comb begin
		ras_ctrl = '0;
		ras_ctrl.push = allow && (dec.rd == REG_RA) && (dec.is_jal || dec.is_jalr);
		ras_ctrl.pop  = allow && dec.is_jalr && (jalr_pred_en || jalr_pred_confirm);

		// undo whatever the flushed stages did to the stack
		ras_ctrl.rollback_pop_id  = pl_flush && push_id;
		ras_ctrl.rollback_push_id = pl_flush && pop_id;
		ras_ctrl.rollback_push_ex = pl_flush && pop_ex;

		// mv rd, ra
		ras_ctrl.track_wr = dec.is_itype_alu && (dec.func3 == 3'b000) &&
			dec.imm_is_zero && (dec.rs1 == REG_RA) && dec.reg_write;
		ras_ctrl.track_rd = dec.rd;
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			push_id <= 1'b0;
			pop_id  <= 1'b0;
			pop_ex  <= 1'b0;
		end else if (!pl_stall_ex) begin
			push_id <= ras_ctrl.push;
			pop_id  <= ras_ctrl.pop;
			pop_ex  <= pop_id;
		end
	end

	a_pop_vs_rollback: assert property (
		@(posedge clk) disable iff (!rst_n)
		ras_ctrl.pop |-> !(ras_ctrl.rollback_pop_id || ras_ctrl.rollback_push_id ||
			ras_ctrl.rollback_push_ex)
	) else $error("stack pop and rollback in the same cycle");

endmodule

`default_nettype wire

// File: rtl/return_addr_stack.sv
`timescale 1ns/1ps
`default_nettype none

module return_addr_stack #(
	parameter int RAS_DEPTH = 8
) (
	input  logic                     clk,
	input  logic                     rst_n,
	input  pipe_ctrl_pkg::ras_ctrl_t ctrl,
	input  logic [31:0]              pc,
	output logic [31:0]              target,
	output pipe_ctrl_pkg::reg_idx_t  ras_alias
);
	import pipe_ctrl_pkg::*;

	localparam int PTR_W = $clog2(RAS_DEPTH);
	localparam int CNT_W = $clog2(RAS_DEPTH + 1);

	logic [31:0]      ret_mem [RAS_DEPTH];
	logic [31:0]      ret_addr;
	logic [PTR_W-1:0] ptr;        // next free slot
	logic [PTR_W-1:0] top_ptr;
	logic [PTR_W-1:0] ptr_next;
	logic [CNT_W-1:0] count;
	logic [CNT_W-1:0] count_next;
	int               step;
	int               cnt_sum;

	assign ret_addr = pc + 32'd4;
	assign top_ptr  = ptr - 1'b1;
	assign target   = ret_mem[top_ptr];

	// ----------------------------------------
	// net pointer movement this cycle
	always_comb begin
		step = 0;
		if (ctrl.push && !ctrl.pop)
			step = step + 1;
		if (ctrl.pop && !ctrl.push)
			step = step - 1;
		if (ctrl.rollback_pop_id)
			step = step - 1;
		if (ctrl.rollback_push_id)
			step = step + 1;   // popped entry is still in place
		if (ctrl.rollback_push_ex)
			step = step + 1;

		cnt_sum = int'(count) + step;
		if (cnt_sum < 0)
			count_next = '0;
		else if (cnt_sum > RAS_DEPTH)
			count_next = CNT_W'(RAS_DEPTH);   // oldest entry overwritten
		else
			count_next = CNT_W'(cnt_sum);
		if (ctrl.push && ctrl.pop && (count == '0))
			count_next = CNT_W'(1);

		ptr_next = ptr + PTR_W'(step);   // wraps around the buffer
	end

	always_ff @(posedge clk) begin
		if (ctrl.push) begin
			if (ctrl.pop)
				ret_mem[top_ptr] <= ret_addr;   // replace top
			else
				ret_mem[ptr] <= ret_addr;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			ptr   <= '0;
			count <= '0;
		end else begin
			ptr   <= ptr_next;
			count <= count_next;
		end
	end

	// ----------------------------------------
	// register currently holding a copy of ra
	always_ff @(posedge clk) begin
		if (!rst_n)
			ras_alias <= REG_RA;
		else if (ctrl.track_wr)
			ras_alias <= ctrl.track_rd;
	end

	a_count_bound: assert property (
		@(posedge clk) disable iff (!rst_n)
		count <= CNT_W'(RAS_DEPTH)
	) else $error("stack count above depth");

endmodule

`default_nettype wire

// File: rtl/front_ctrl_top.sv
`timescale 1ns/1ps
`default_nettype none

module front_ctrl_top #(
	parameter int RAS_DEPTH = 8
) (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic [31:0]             inst,
	input  logic [31:0]             pc,
	input  logic                    pl_flush,
	input  logic                    pl_stall_ex,
	input  logic                    jalr_pred_confirm,
	output pipe_ctrl_pkg::fwd_sel_t rs1_fwd,
	output pipe_ctrl_pkg::fwd_sel_t rs2_fwd,
	output logic                    b_pred_en,
	output logic                    jalr_pred_en,
	output logic                    pl_stall_if,
	output logic [31:0]             ras_target,
	output logic                    ras_push,
	output logic                    ras_pop
);
	import pipe_ctrl_pkg::*;

	dec_info_t   dec;
	stage_info_t st_id;
	stage_info_t st_ex;
	stage_info_t st_mem;
	stage_info_t st_wb;
	ras_ctrl_t   ras_ctrl;
	reg_idx_t    ras_alias;

	// ----------------------------------------
	inst_decode u_decode (
		.inst (inst),
		.dec  (dec)
	);

	stage_track u_track (
		.clk         (clk),
		.rst_n       (rst_n),
		.dec         (dec),
		.pl_stall_if (pl_stall_if),   // fed back from hazard control
		.pl_stall_ex (pl_stall_ex),
		.pl_flush    (pl_flush),
		.st_id       (st_id),
		.st_ex       (st_ex),
		.st_mem      (st_mem),
		.st_wb       (st_wb)
	);

	pipe_hazard_ctrl u_hazard (
		.clk               (clk),
		.rst_n             (rst_n),
		.dec               (dec),
		.st_id             (st_id),
		.st_ex             (st_ex),
		.st_mem            (st_mem),
		.st_wb             (st_wb),
		.pl_flush          (pl_flush),
		.pl_stall_ex       (pl_stall_ex),
		.jalr_pred_confirm (jalr_pred_confirm),
		.ras_alias         (ras_alias),
		.rs1_fwd           (rs1_fwd),
		.rs2_fwd           (rs2_fwd),
		.b_pred_en         (b_pred_en),
		.jalr_pred_en      (jalr_pred_en),
		.pl_stall_if       (pl_stall_if),
		.ras_ctrl          (ras_ctrl)
	);

	return_addr_stack #(
		.RAS_DEPTH (RAS_DEPTH)
	) u_ras (
		.clk       (clk),
		.rst_n     (rst_n),
		.ctrl      (ras_ctrl),
		.pc        (pc),
		.target    (ras_target),
		.ras_alias (ras_alias)
	);

	// stack pulses out for observation
	assign ras_push = ras_ctrl.push;
	assign ras_pop  = ras_ctrl.pop;

endmodule

`default_nettype wire

// File: tb/tb_front_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module tb_front_ctrl;

	localparam real         CLK_PERIOD   = 4.0;
	localparam int          RESET_CYCLES = 3;
	localparam int          SLACK_CYCLES = 20;   // reset plus margin
	localparam string       PAT_FILE     = "tb/front_ctrl_patterns.txt";
	localparam logic [31:0] NOP          = 32'h0000_0013;   // addi x0, x0, 0

	// one line of the pattern file
	typedef struct packed {
		logic [31:0] inst;
		logic [31:0] pc;
		logic        flush;
		logic        stall_ex;
		logic        confirm;
		logic [1:0]  rs1_fwd;
		logic [1:0]  rs2_fwd;
		logic        b_pred_en;
		logic        jalr_pred_en;
		logic        stall_if;
		logic        push;
		logic        pop;
		logic        target_valid;   // clear when the target is a don't-care
		logic [31:0] target;
	} pattern_t;

	logic        clk;
	logic        rst_n;
	logic [31:0] inst;
	logic [31:0] pc;
	logic        pl_flush;
	logic        pl_stall_ex;
	logic        jalr_pred_confirm;
	logic [1:0]  rs1_fwd;
	logic [1:0]  rs2_fwd;
	logic        b_pred_en;
	logic        jalr_pred_en;
	logic        pl_stall_if;
	logic [31:0] ras_target;
	logic        ras_push;
	logic        ras_pop;

	pattern_t pats[$];
	int       errors;
	int       checks;
	logic     loaded;

	front_ctrl_top #(
		.RAS_DEPTH (8)
	) u_front_ctrl_top (
		.clk               (clk),
		.rst_n             (rst_n),
		.inst              (inst),
		.pc                (pc),
		.pl_flush          (pl_flush),
		.pl_stall_ex       (pl_stall_ex),
		.jalr_pred_confirm (jalr_pred_confirm),
		.rs1_fwd           (rs1_fwd),
		.rs2_fwd           (rs2_fwd),
		.b_pred_en         (b_pred_en),
		.jalr_pred_en      (jalr_pred_en),
		.pl_stall_if       (pl_stall_if),
		.ras_target        (ras_target),
		.ras_push          (ras_push),
		.ras_pop           (ras_pop)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	// ----------------------------------------
	// pattern file
	task automatic read_patterns(output bit ok);
		int          fd;
		int          n;
		string       line;
		string       tgt;
		logic [31:0] f [12];
		pattern_t    p;

		ok = 1'b0;
		fd = $fopen(PAT_FILE, "r");
		if (fd == 0) begin
			$display("cannot open pattern file %s", PAT_FILE);
			return;
		end
		while ($fgets(line, fd) != 0) begin
			if (line.len() == 0 || line.getc(0) == "#")
				continue;   // comment
			n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %s",
				f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9],
				f[10], f[11], tgt);
			if (n <= 0)
				continue;   // blank line
			if (n != 13) begin
				$display("pattern line %0d is malformed, %0d fields read", pats.size(), n);
				errors++;
				continue;
			end
			p.inst         = f[0];
			p.pc           = f[1];
			p.flush        = f[2][0];
			p.stall_ex     = f[3][0];
			p.confirm      = f[4][0];
			p.rs1_fwd      = f[5][1:0];
			p.rs2_fwd      = f[6][1:0];
			p.b_pred_en    = f[7][0];
			p.jalr_pred_en = f[8][0];
			p.stall_if     = f[9][0];
			p.push         = f[10][0];
			p.pop          = f[11][0];
			p.target_valid = (tgt != "-");
			p.target       = '0;
			if (p.target_valid)
				void'($sscanf(tgt, "%h", p.target));
			pats.push_back(p);
		end
		$fclose(fd);
		ok = (pats.size() > 0);
		if (!ok)
			$display("pattern file %s holds no patterns", PAT_FILE);
	endtask

	task automatic apply_inputs(input pattern_t p);
		inst              = p.inst;
		pc                = p.pc;
		pl_flush          = p.flush;
		pl_stall_ex       = p.stall_ex;
		jalr_pred_confirm = p.confirm;
	endtask

	// ----------------------------------------
	// output compare
	task automatic compare_value(input string what, input int idx,
			input logic [31:0] got, input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("** Error at %0.1f ns: pattern %0d, %s is %0h, expected %0h",
				$realtime, idx, what, got, exp);
		end
	endtask

	task automatic check_outputs(input int idx, input pattern_t p);
		compare_value("rs1_fwd", idx, rs1_fwd, p.rs1_fwd);
		compare_value("rs2_fwd", idx, rs2_fwd, p.rs2_fwd);
		compare_value("b_pred_en", idx, b_pred_en, p.b_pred_en);
		compare_value("jalr_pred_en", idx, jalr_pred_en, p.jalr_pred_en);
		compare_value("pl_stall_if", idx, pl_stall_if, p.stall_if);
		compare_value("ras_push", idx, ras_push, p.push);
		compare_value("ras_pop", idx, ras_pop, p.pop);
		if (p.target_valid)
			compare_value("ras_target", idx, ras_target, p.target);
	endtask

	// ----------------------------------------
	// main sequence
	initial begin
		bit ok;

		clk               = 1'b0;
		rst_n             = 1'b0;
		inst              = NOP;
		pc                = '0;
		pl_flush          = 1'b0;
		pl_stall_ex       = 1'b0;
		jalr_pred_confirm = 1'b0;
		errors            = 0;
		checks            = 0;
		loaded            = 1'b0;

		read_patterns(ok);
		if (!ok) begin
			$display("run stopped, no usable stimulus");
			$display("TESTS FAILED");
			$finish;
		end else begin
			loaded = 1'b1;
			repeat (RESET_CYCLES) @(posedge clk);
			@(negedge clk);
			rst_n = 1'b1;
			foreach (pats[i]) begin
				apply_inputs(pats[i]);
				#(CLK_PERIOD / 2 - 0.5);   // just ahead of the rising edge
				check_outputs(i, pats[i]);
				@(negedge clk);
			end
			$display("%0d patterns, %0d checks, %0d errors", pats.size(), checks, errors);
			if (errors == 0)
				$display("TESTS PASSED");
			else
				$display("TESTS FAILED");
			$finish;
		end
	end

	// watchdog, sized from the pattern count
	initial begin
		wait (loaded === 1'b1);
		#((pats.size() + SLACK_CYCLES) * CLK_PERIOD);
		$display("timeout, patterns not done after %0d cycles", pats.size() + SLACK_CYCLES);
		$display("%0d patterns, %0d checks, %0d errors", pats.size(), checks, errors);
		$display("TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: tb/front_ctrl_patterns.txt
# inst pc flush stall_ex confirm | rs1_fwd rs2_fwd b_pred_en jalr_pred_en stall_if push pop target
# all hex, one line per cycle, target - means don't care
00c58533 00000000 0 0 0 0 0 0 0 0 0 0 -
000506b3 00000000 0 0 0 0 0 0 0 0 0 0 -
000506b3 00000000 0 0 0 0 0 0 0 0 0 0 -
00a00733 00000000 0 0 0 0 2 0 0 0 0 0 -
000506b3 00000000 0 0 0 1 0 0 0 0 0 0 -
000506b3 00000000 0 0 0 0 0 0 0 0 0 0 -
00c58533 00000000 0 0 0 0 0 0 0 0 0 0 -
00c58533 00000000 0 0 0 0 0 0 0 0 0 0 -
00000013 00000000 0 0 0 0 0 0 0 0 0 0 -
00000013 00000000 0 0 0 0 0 0 0 0 0 0 -
000506b3 00000000 0 0 0 3 0 0 0 0 0 0 -
0005a503 00000000 0 0 0 0 0 0 0 0 0 0 -
00000013 00000000 0 0 0 0 0 0 0 0 0 0 -
00000013 00000000 0 0 0 0 0 0 0 0 0 0 -
00050063 00000000 0 0 0 0 0 1 0 0 0 0 -
00c58533 00000000 0 0 0 0 0 0 0 0 0 0 -
00050063 00000000 0 0 0 0 0 1 0 0 0 0 -
00000013 00000000 0 0 0 0 0 0 0 0 0 0 -
00050063 00000000 0 0 0 2 0 0 0 0 0 0 -
010000ef 00000100 0 0 0 0 0 0 0 0 1 0 -
010000ef 00000200 0 0 0 0 0 0 0 0 1 0 00000104
00008067 00000000 0 0 0 0 0 0 1 0 0 1 00000204
00000013 00000000 0 0 0 0 0 0 0 0 0 0 00000104
00008293 00000000 0 0 0 3 0 0 0 0 0 0 00000104
00028067 00000000 0 0 0 0 0 0 1 0 0 1 00000104
00c58533 00000000 0 0 0 0 0 0 0 0 0 0 -
00000013 00000000 0 0 0 0 0 0 0 0 0 0 -
00050067 00000000 0 0 0 0 0 0 0 1 0 0 -
00050067 00000000 0 0 0 2 0 0 0 0 0 0 -
010000ef 00000300 0 0 0 0 0 0 0 0 1 0 -
010000ef 00000400 0 0 0 0 0 0 0 0 1 0 00000304
00000013 00000000 1 0 0 0 0 0 0 0 0 0 00000404
00000013 00000000 0 0 0 0 0 0 0 0 0 0 00000304
00008067 00000000 0 0 1 1 0 0 0 0 0 1 00000304
00000013 00000000 1 0 0 0 0 0 0 0 0 0 -
00000013 00000000 0 0 0 0 0 0 0 0 0 0 00000304
00c58533 00000000 0 0 0 0 0 0 0 0 0 0 00000304
00000013 00000000 0 0 0 0 0 0 0 0 0 0 00000304
00000013 00000000 0 0 0 0 0 0 0 0 0 0 00000304
000506b3 00000000 0 1 0 2 0 0 0 0 0 0 00000304
000506b3 00000000 0 1 0 1 0 0 0 0 0 0 00000304
000506b3 00000000 0 0 0 0 0 0 0 0 0 0 00000304
010000ef 00000500 0 1 0 0 0 0 0 0 0 0 00000304
010000ef 00000500 0 0 0 0 0 0 0 0 1 0 00000304
00008067 00000000 0 1 0 0 0 0 1 0 0 0 00000504
00008067 00000000 0 0 0 0 0 0 1 0 0 1 00000504
00000013 00000000 0 0 0 0 0 0 0 0 0 0 00000304
00000013 00000000 0 0 0 0 0 0 0 0 0 0 00000304

// File: all.f
rtl/pipe_ctrl_pkg.sv
rtl/inst_decode.sv
rtl/stage_track.sv
rtl/pipe_hazard_ctrl.sv
rtl/return_addr_stack.sv
rtl/front_ctrl_top.sv
tb/tb_front_ctrl.sv

// File: Makefile
SIM       := verilator
TOP       := tb_front_ctrl
RTL_TOP   := front_ctrl_top
FILELIST  := all.f
BUILD     := obj_dir
LOG       := sim.log
SIMFLAGS  := --binary --timing --assert -Wno-fatal
LINTFLAGS := --lint-only --timing -Wall

SRCS := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run lint clean

all: run

$(BUILD)/V$(TOP): $(SRCS) $(FILELIST)
	$(SIM) $(SIMFLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)

run: $(BUILD)/V$(TOP)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@grep -qx "TESTS PASSED" $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }

lint:
	$(SIM) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD) $(LOG)
